// ==== design/wavegen_pkg.sv ====
`default_nettype none

package wavegen_pkg;

  ////////////////////////////////////////////////////////////////////
  // sample and word types
  ////////////////////////////////////////////////////////////////////

  // one waveform sample, same width as the host pipe
  typedef logic signed [15:0] sample_t;

  // playback word, two consecutive samples
  typedef struct packed {
    sample_t hi;  // odd address
    sample_t lo;  // even address
  } wave_word_t;

  // trigger data, same layout as wave_word_t
  typedef logic [31:0] trig_word_t;

  // clamp limits for lane sums
  localparam sample_t SAMPLE_MAX = 16'sh7fff;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

  ////////////////////////////////////////////////////////////////////
  // host pipe
  ////////////////////////////////////////////////////////////////////

  // one pipe transaction, 20 bits
  // write and read are exclusive, rewind wins over both
  typedef struct packed {
    logic    write;        // store data at pipe address
    logic    read;         // fetch sample at pipe address
    logic    rewind;       // pipe address back to zero
    logic    channel_sel;  // 0 = chan a, 1 = chan b
    sample_t data;
  } pipe_req_t;

  // playback words per channel unless the top says otherwise
  localparam int unsigned DEFAULT_DEPTH_WORDS = 256;

endpackage

`default_nettype wire

// ==== design/waveform_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

// one channel of stored stimulus
// samples go in 16 bits at a time over the pipe, come out 32 bits per pop
module waveform_buffer
  import wavegen_pkg::*;
#(
  parameter int unsigned DEPTH_WORDS = DEFAULT_DEPTH_WORDS,
  parameter bit          CHANNEL     = 1'b0
) (
  input  wire logic       pipe_clk,
  input  wire logic       reset,
  input  wire pipe_req_t  pipe_req,
  input  wire logic       pop,         // playback strobe
  output sample_t         rd_data,     // pipe readback, zero when idle
  output wave_word_t      word,        // playback word
  output logic            word_valid
);

  localparam int unsigned WORD_AW   = $clog2(DEPTH_WORDS);
  localparam int unsigned SAMPLE_AW = WORD_AW + 1;  // pipe addresses samples

  //////////////////////////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////////////////////////

  logic sel;       // this channel addressed
  logic wr_en;
  logic rd_en;
  logic rewind_en;

  assign sel       = (pipe_req.channel_sel == CHANNEL);
  assign rewind_en = sel && pipe_req.rewind;
  assign wr_en     = sel && pipe_req.write && !pipe_req.rewind;  // rewind wins
  assign rd_en     = sel && pipe_req.read && !pipe_req.rewind;

  //////////////////////////////////////////////////////////////////////
  // addresses
  //////////////////////////////////////////////////////////////////////

  logic [SAMPLE_AW-1:0] pipe_addr;  // shared by write and read
  logic [WORD_AW-1:0]   pop_addr;   // playback word address

  // wraps at 2*DEPTH_WORDS by width
  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      pipe_addr <= '0;
    end else if (rewind_en) begin
      pipe_addr <= '0;
    end else if (wr_en || rd_en) begin
      pipe_addr <= pipe_addr + 1'b1;
    end
  end

  // wraps at DEPTH_WORDS by width
  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      pop_addr <= '0;
    end else if (pop) begin
      pop_addr <= pop_addr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////////////////////////

  // split even/odd so one pop fetches a whole pair
  sample_t mem_even [0:DEPTH_WORDS-1];
  sample_t mem_odd  [0:DEPTH_WORDS-1];

  logic [WORD_AW-1:0] pipe_row;  // pair holding the pipe sample
  logic               pipe_odd;

  assign pipe_row = pipe_addr[SAMPLE_AW-1:1];
  assign pipe_odd = pipe_addr[0];

  // pipe side write, 16 bits into one bank
  always_ff @(posedge pipe_clk) begin
    if (wr_en && !pipe_odd) begin
      mem_even[pipe_row] <= pipe_req.data;
    end
    if (wr_en && pipe_odd) begin
      mem_odd[pipe_row] <= pipe_req.data;
    end
  end

  // pipe side read, one cycle latency
  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= pipe_odd ? mem_odd[pipe_row] : mem_even[pipe_row];
    end else begin
      rd_data <= '0;  // keeps the OR merge clean
    end
  end

  //////////////////////////////////////////////////////////////////////
  // playback
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (pop) begin
      word.lo <= mem_even[pop_addr];
      word.hi <= mem_odd[pop_addr];
    end
  end

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= pop;
    end
  end

  // host protocol, checked on the raw request
  a_no_wr_and_rd : assert property (
    @(posedge pipe_clk) disable iff (reset)
    !(pipe_req.write && pipe_req.read)
  );

endmodule

`default_nettype wire

// ==== design/wave_combiner.sv ====
`timescale 1ns/10ps
`default_nettype none

// sums chan a and chan b lane by lane, or passes trigger data
// also merges the two pipe readback paths
module wave_combiner
  import wavegen_pkg::*;
(
  input  wire logic        pipe_clk,
  input  wire logic        reset,
  input  wire wave_word_t  word_a,
  input  wire wave_word_t  word_b,
  input  wire logic        valid_a,
  input  wire logic        valid_b,
  input  wire sample_t     rd_a,
  input  wire sample_t     rd_b,
  input  wire logic        is_from_trigger,
  input  wire trig_word_t  data_from_trig,
  output sample_t          pipe_out_data,
  output wave_word_t       wave,
  output logic             wave_valid
);

  // signed add clamped to the sample range
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic signed [16:0] s;
    s = {a[15], a} + {b[15], b};  // one guard bit
    if (s[16] != s[15]) begin     // overflow either way
      return s[16] ? SAMPLE_MIN : SAMPLE_MAX;
    end
    return s[15:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // lane sums
  //////////////////////////////////////////////////////////////////////

  wave_word_t sum_word;
  wave_word_t next_wave;

  always_comb begin
    sum_word.hi = sat_add(word_a.hi, word_b.hi);
    sum_word.lo = sat_add(word_a.lo, word_b.lo);
  end

  // trigger bypass, decided in the same stage as the words
  assign next_wave = is_from_trigger ? wave_word_t'(data_from_trig) : sum_word;

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      wave       <= '0;
      wave_valid <= 1'b0;
    end else begin
      wave_valid <= valid_a;
      if (valid_a) begin
        wave <= next_wave;  // holds between pops
      end
    end
  end

  // only the channel that was read drives non-zero
  assign pipe_out_data = rd_a | rd_b;

  // both buffers see the same pop, so they must stay in step
  a_valid_lockstep : assert property (
    @(posedge pipe_clk) disable iff (reset)
    valid_a == valid_b
  );

endmodule

`default_nettype wire

// ==== design/stim_wavegen_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// two waveform channels side by side, summed into one stimulus word
module stim_wavegen_top
  import wavegen_pkg::*;
#(
  parameter int unsigned DEPTH_WORDS = DEFAULT_DEPTH_WORDS
) (
  input  wire logic        pipe_clk,
  input  wire logic        reset,
  input  wire pipe_req_t   pipe_req,
  input  wire logic        pop_strobe,       // next playback word
  input  wire logic        is_from_trigger,
  input  wire trig_word_t  data_from_trig,
  output sample_t          pipe_out_data,
  output wave_word_t       wave,
  output logic             wave_valid
);

  wave_word_t word_a, word_b;
  logic       valid_a, valid_b;
  sample_t    rd_a, rd_b;

  ////////////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////////////

  waveform_buffer #(.DEPTH_WORDS(DEPTH_WORDS), .CHANNEL(1'b0)) chan_a (
    .pipe_clk   (pipe_clk),
    .reset      (reset),
    .pipe_req   (pipe_req),
    .pop        (pop_strobe),
    .rd_data    (rd_a),
    .word       (word_a),
    .word_valid (valid_a)
  );

  waveform_buffer #(.DEPTH_WORDS(DEPTH_WORDS), .CHANNEL(1'b1)) chan_b (
    .pipe_clk   (pipe_clk),
    .reset      (reset),
    .pipe_req   (pipe_req),
    .pop        (pop_strobe),
    .rd_data    (rd_b),
    .word       (word_b),
    .word_valid (valid_b)
  );

  ////////////////////////////////////////////////////////////////////
  // sum, bypass and readback merge
  ////////////////////////////////////////////////////////////////////

  wave_combiner combiner (
    .pipe_clk        (pipe_clk),
    .reset           (reset),
    .word_a          (word_a),
    .word_b          (word_b),
    .valid_a         (valid_a),
    .valid_b         (valid_b),
    .rd_a            (rd_a),
    .rd_b            (rd_b),
    .is_from_trigger (is_from_trigger),
    .data_from_trig  (data_from_trig),
    .pipe_out_data   (pipe_out_data),  // 1 cycle after read
    .wave            (wave),           // 2 cycles after pop
    .wave_valid      (wave_valid)
  );

endmodule

`default_nettype wire

// ==== tests/tb_stim_wavegen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_stim_wavegen
  import wavegen_pkg::*;
;

  localparam int DEPTH_WORDS = 8;
  localparam int SAMPLES     = 2 * DEPTH_WORDS;  // pipe addresses per channel
  localparam int CLK_PERIOD  = 100;
  localparam int TRIG_POPS   = 10;
  // reset, idle, readback, reload, playback with gaps, trigger, tail
  localparam int TEST_CYCLES = 8 + 6 * (SAMPLES + 1) + 2 * (DEPTH_WORDS + 4) + TRIG_POPS + 16;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 50) * CLK_PERIOD;

  logic       pipe_clk = 1'b0;
  logic       reset;
  pipe_req_t  pipe_req;
  logic       pop_strobe;
  logic       is_from_trigger;
  trig_word_t data_from_trig;
  sample_t    pipe_out_data;
  wave_word_t wave;
  logic       wave_valid;

  logic [31:0] rng;  // xorshift state

  stim_wavegen_top #(.DEPTH_WORDS(DEPTH_WORDS)) uut (
    .pipe_clk        (pipe_clk),
    .reset           (reset),
    .pipe_req        (pipe_req),
    .pop_strobe      (pop_strobe),
    .is_from_trigger (is_from_trigger),
    .data_from_trig  (data_from_trig),
    .pipe_out_data   (pipe_out_data),
    .wave            (wave),
    .wave_valid      (wave_valid)
  );

  always #(CLK_PERIOD / 2) pipe_clk = ~pipe_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // lane sum by integer range, clamped at the sample limits
  function automatic sample_t clamp_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 32767) return 16'sh7fff;
    if (s < -32768) return 16'sh8000;
    return sample_t'(s);
  endfunction

  // first three positions force both clamps and a plain -1 sum
  function automatic sample_t pick_sample(input logic ch, input int pos, input logic [31:0] rnd);
    case (pos)
      0:       return 16'sh7fff;
      1:       return 16'sh8000;
      2:       return ch ? 16'sh8000 : 16'sh7fff;
      default: return sample_t'(rnd[15:0]);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////

  sample_t                      model_mem [0:1][0:SAMPLES-1];  // every sample written
  logic [$clog2(SAMPLES)-1:0]   model_pipe_addr [0:1];
  logic [$clog2(DEPTH_WORDS)-1:0] model_pop_addr, m1_idx, exp_idx;
  sample_t    exp_rd;
  wave_word_t m1_a, m1_b, exp_wave, word0_exp;
  logic       m1_valid, exp_valid, exp_trig, seen_pop;

  always @(posedge pipe_clk) begin
    if (reset) begin
      model_pipe_addr[0] <= '0;
      model_pipe_addr[1] <= '0;
      exp_rd             <= '0;
    end else begin
      exp_rd <= '0;  // zero unless a read is in flight
      if (pipe_req.rewind) begin
        model_pipe_addr[pipe_req.channel_sel] <= '0;
      end else if (pipe_req.write) begin
        model_mem[pipe_req.channel_sel][model_pipe_addr[pipe_req.channel_sel]] <= pipe_req.data;
        model_pipe_addr[pipe_req.channel_sel] <= model_pipe_addr[pipe_req.channel_sel] + 1'b1;
      end else if (pipe_req.read) begin
        exp_rd <= model_mem[pipe_req.channel_sel][model_pipe_addr[pipe_req.channel_sel]];
        model_pipe_addr[pipe_req.channel_sel] <= model_pipe_addr[pipe_req.channel_sel] + 1'b1;
      end
    end
  end

  // pop -> raw words -> sum or trigger, two stages
  always @(posedge pipe_clk) begin
    if (reset) begin
      model_pop_addr <= '0;
      m1_valid       <= 1'b0;
      exp_valid      <= 1'b0;
      exp_wave       <= '0;
      exp_trig       <= 1'b0;
      exp_idx        <= '0;
      seen_pop       <= 1'b0;
    end else begin
      m1_valid  <= pop_strobe;
      exp_valid <= m1_valid;
      if (pop_strobe) begin
        seen_pop       <= 1'b1;
        m1_idx         <= model_pop_addr;
        m1_a           <= wave_word_t'({model_mem[0][{model_pop_addr, 1'b1}],
                                        model_mem[0][{model_pop_addr, 1'b0}]});
        m1_b           <= wave_word_t'({model_mem[1][{model_pop_addr, 1'b1}],
                                        model_mem[1][{model_pop_addr, 1'b0}]});
        model_pop_addr <= model_pop_addr + 1'b1;  // wraps at depth
      end
      if (m1_valid) begin
        exp_idx  <= m1_idx;
        exp_trig <= is_from_trigger;
        if (is_from_trigger) begin
          exp_wave <= wave_word_t'(data_from_trig);
        end else begin
          exp_wave.hi <= clamp_sum(m1_a.hi, m1_b.hi);
          exp_wave.lo <= clamp_sum(m1_a.lo, m1_b.lo);
        end
      end
    end
  end

  always_comb begin
    word0_exp.hi = clamp_sum(model_mem[0][1], model_mem[1][1]);
    word0_exp.lo = clamp_sum(model_mem[0][0], model_mem[1][0]);
  end

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL %s expected %h actual %h", name, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "check %s did not hold", name);
  endtask

  a_reset_idle : assert property (@(posedge pipe_clk) disable iff (reset)
    !seen_pop |-> (!wave_valid && wave == '0))
    else report_mismatch("reset idle", 32'h0, $sampled(wave));

  a_readback : assert property (@(posedge pipe_clk) disable iff (reset)
    pipe_out_data == exp_rd)
    else report_mismatch("readback", 32'($sampled(exp_rd)), 32'($sampled(pipe_out_data)));

  a_valid_timing : assert property (@(posedge pipe_clk) disable iff (reset)
    wave_valid == exp_valid)  // pop plus 2 cycles
    else report_mismatch("wave_valid timing", 32'($sampled(exp_valid)),
                         32'($sampled(wave_valid)));

  a_wave : assert property (@(posedge pipe_clk) disable iff (reset)
    wave_valid |-> wave == exp_wave)
    else report_mismatch($sampled(exp_trig) ? "trigger bypass" : "playback sum",
                         $sampled(exp_wave), $sampled(wave));

  a_wrap : assert property (@(posedge pipe_clk) disable iff (reset)
    (wave_valid && !exp_trig && exp_idx == '0) |-> wave == word0_exp)
    else report_mismatch("wrap", $sampled(word0_exp), $sampled(wave));

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input pipe_req_t req, input logic pop, input logic trig,
                             input trig_word_t tdata);
    @(posedge pipe_clk);
    pipe_req        <= req;
    pop_strobe      <= pop;
    is_from_trigger <= trig;
    data_from_trig  <= tdata;
  endtask

  task automatic pipe_op(input logic wr, input logic rd, input logic rew, input logic ch,
                         input sample_t d);
    pipe_req_t req;
    req             = '0;
    req.write       = wr;
    req.read        = rd;
    req.rewind      = rew;
    req.channel_sel = ch;
    req.data        = d;
    drive_cycle(req, 1'b0, 1'b0, '0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle('0, 1'b0, 1'b0, '0);
  endtask

  initial begin
    reset           <= 1'b1;
    pipe_req        <= '0;
    pop_strobe      <= 1'b0;
    is_from_trigger <= 1'b0;
    data_from_trig  <= '0;
    rng = 32'h25b;
    repeat (2) @(posedge pipe_clk);
    reset <= 1'b0;
    idle_cycles(4);  // outputs must stay quiet

    // random load, then read everything back
    for (int ch = 0; ch < 2; ch++) begin
      pipe_op(1'b0, 1'b0, 1'b1, ch[0], '0);
      for (int i = 0; i < SAMPLES; i++) begin
        rng = xorshift32(rng);
        pipe_op(1'b1, 1'b0, 1'b0, ch[0], sample_t'(rng[15:0]));
      end
    end
    for (int ch = 0; ch < 2; ch++) begin
      pipe_op(1'b0, 1'b0, 1'b1, ch[0], '0);
      for (int i = 0; i < SAMPLES; i++) pipe_op(1'b0, 1'b1, 1'b0, ch[0], '0);
    end
    idle_cycles(2);

    // reload with extremes up front
    for (int ch = 0; ch < 2; ch++) begin
      pipe_op(1'b0, 1'b0, 1'b1, ch[0], '0);
      for (int i = 0; i < SAMPLES; i++) begin
        rng = xorshift32(rng);
        pipe_op(1'b1, 1'b0, 1'b0, ch[0], pick_sample(ch[0], i, rng));
      end
    end

    // past depth so word zero comes round again
    for (int k = 0; k < DEPTH_WORDS + 4; k++) begin
      drive_cycle('0, 1'b1, 1'b0, '0);
      if (k % 2 == 1) idle_cycles(1);  // mix gaps and back to back
    end
    idle_cycles(3);

    // trigger data replaces the sums, last pop falls back to a sum
    for (int k = 0; k < TRIG_POPS; k++) begin
      rng = xorshift32(rng);
      drive_cycle('0, 1'b1, 1'b1, rng);
    end
    idle_cycles(4);

    $display("TEST OK");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the test sequence did not complete in time");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== build.f ====
design/wavegen_pkg.sv
design/waveform_buffer.sv
design/wave_combiner.sv
design/stim_wavegen_top.sv
tests/tb_stim_wavegen.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is 0 only if the simulation prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_stim_wavegen \
  -f build.f \
  -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee /dev/stderr | grep -q "TEST OK" \
  && echo "simulation passed" \
  || {
    echo "simulation failed"
    exit 1
  }

exit 0
